// ==== verilog.f ====
src/rt_scene_pkg.sv
src/uart_rx.sv
src/uart_memflash_rtx.sv
src/scene_store.sv
src/scene_loader_top.sv
testbench/tb_scene_loader.sv

// ==== Bender.yml ====
package:
  name: rt_scene_loader

sources:
  - src/rt_scene_pkg.sv
  - src/uart_rx.sv
  - src/uart_memflash_rtx.sv
  - src/scene_store.sv
  - src/scene_loader_top.sv
  - target: test
    files:
      - testbench/tb_scene_loader.sv

// ==== testbench/tb_scene_loader.sv ====
`timescale 1ns/1ps

module tb_scene_loader import rt_scene_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        uart_rxd;
  logic        loading;
  logic [71:0] cam_origin;
  logic [71:0] cam_right;
  logic [71:0] cam_forward;
  logic [71:0] cam_up;
  logic [7:0]  num_objs_out;
  logic [7:0]  max_bounces;
  logic [3:0]  obj_rd_addr;
  logic [71:0] obj_rd_data;

  int          value_errors;
  int          timeout_errors;

  // expected scene contents.
  logic [71:0] cam_model [4];
  logic [71:0] obj_model [num_objs];
  logic [7:0]  num_objs_model;
  logic [7:0]  bounce_model;

  scene_loader_top u_scene_loader_top (
    .clk          (clk),
    .rst          (rst),
    .uart_rxd     (uart_rxd),
    .loading      (loading),
    .cam_origin   (cam_origin),
    .cam_right    (cam_right),
    .cam_forward  (cam_forward),
    .cam_up       (cam_up),
    .num_objs_out (num_objs_out),
    .max_bounces  (max_bounces),
    .obj_rd_addr  (obj_rd_addr),
    .obj_rd_data  (obj_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // compare and wait helpers
  // ==========================================================================

  task automatic check_vec72(input string name, input logic [71:0] expected,
                             input logic [71:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  // current value of a top-level output, by port name.
  function automatic logic [71:0] probe(input string name);
    probe = '0;
    if (name == "cam_origin")        probe = cam_origin;
    else if (name == "cam_right")    probe = cam_right;
    else if (name == "cam_forward")  probe = cam_forward;
    else if (name == "cam_up")       probe = cam_up;
    else if (name == "num_objs_out") probe = 72'(num_objs_out);
    else if (name == "max_bounces")  probe = 72'(max_bounces);
    else if (name == "obj_rd_data")  probe = obj_rd_data;
    else if (name == "loading")      probe = 72'(loading);
  endfunction

  // outputs are sampled on the falling edge, away from the drive edge.
  task automatic wait_for(input string name, input logic [71:0] expected,
                          input int max_cycles);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (probe(name) !== expected && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (probe(name) !== expected) begin
      timeout_errors++;
      $display("timeout: %s did not reach its expected value in %0d cycles",
               name, max_cycles);
    end
  endtask

  task automatic check_scene();
    cam_sel_e sel;
    @(negedge clk);
    for (int s = 0; s < 4; s++) begin
      sel = cam_sel_e'(s);
      check_vec72(sel.name(), cam_model[s], probe(sel.name()));
    end
    check_byte("num_objs_out", num_objs_model, num_objs_out);
    check_byte("max_bounces", bounce_model, max_bounces);
  endtask

  function automatic logic [71:0] rand72();
    rand72 = {8'($urandom), $urandom, $urandom};
  endfunction

  // ==========================================================================
  // serial driver
  // ==========================================================================

  // start bit, eight data bits lsb first, stop bit, then two idle bit times.
  task automatic send_byte(input logic [7:0] data, input logic bad_stop);
    logic [9:0] frame;
    frame = {~bad_stop, data, 1'b0};
    for (int b = 0; b < 10; b++) begin
      repeat (clks_per_bit) begin
        @(posedge clk);
        uart_rxd <= frame[b];
      end
    end
    repeat (2 * clks_per_bit) begin
      @(posedge clk);
      uart_rxd <= 1'b1;
    end
  endtask

  task automatic send_record(input logic [7:0] cmd, input logic [71:0] data,
                             input int nbytes);
    send_byte(cmd, 1'b0);
    for (int i = 0; i < nbytes; i++) begin
      send_byte(data[8*i +: 8], 1'b0);
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic test_reset();
    for (int s = 0; s < 4; s++) begin
      cam_model[s] = '0;
    end
    num_objs_model = '0;
    bounce_model   = '0;
    check_scene();
    check_bit("loading", 1'b0, loading);
  endtask

  task automatic test_camera_loads();
    cam_sel_e    sel;
    logic [71:0] vec;
    for (int s = 0; s < 4; s++) begin
      sel = cam_sel_e'(s);
      vec = rand72();
      send_record({6'b100000, sel}, vec, cam_bytes);
      cam_model[s] = vec;
      wait_for(sel.name(), vec, 200);
      check_scene();
    end
  endtask

  task automatic test_object_table();
    int          idx_list [6];
    logic [71:0] rec;
    idx_list[0] = 0;
    idx_list[1] = num_objs - 1;
    for (int i = 2; i < 6; i++) begin
      idx_list[i] = $urandom_range(num_objs - 1, 0);
    end
    for (int i = 0; i < 6; i++) begin
      rec = rand72();
      send_record({4'b0000, 4'(idx_list[i])}, rec, obj_bytes);
      obj_model[idx_list[i]] = rec;
    end
    // read back through the registered port.
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      obj_rd_addr <= 4'(idx_list[i]);
      wait_for("obj_rd_data", obj_model[idx_list[i]], 20);
      check_vec72("obj_rd_data", obj_model[idx_list[i]], obj_rd_data);
    end
    check_scene();
  endtask

  task automatic test_count_bounce();
    logic [7:0] cnt;
    logic [7:0] bnc;
    cnt = 8'($urandom_range(255, 1));
    bnc = 8'($urandom_range(255, 1));
    send_byte(8'h84, 1'b0);
    @(negedge clk);
    check_bit("loading", 1'b1, loading);
    send_byte(cnt, 1'b0);
    num_objs_model = cnt;
    wait_for("num_objs_out", 72'(cnt), 200);
    wait_for("loading", 72'(0), 50);
    send_byte(8'h85, 1'b0);
    @(negedge clk);
    check_bit("loading", 1'b1, loading);
    send_byte(bnc, 1'b0);
    bounce_model = bnc;
    wait_for("max_bounces", 72'(bnc), 200);
    wait_for("loading", 72'(0), 50);
    check_scene();
  endtask

  task automatic test_robustness();
    logic [7:0] bnc;
    // a bounce command with a broken stop bit must vanish.
    send_byte(8'h85, 1'b1);
    check_scene();
    check_bit("loading", 1'b0, loading);
    // undecoded command, the parser stays idle.
    send_byte(8'h87, 1'b0);
    check_scene();
    check_bit("loading", 1'b0, loading);
    bnc = bounce_model ^ 8'($urandom_range(255, 1));
    send_record(8'h85, 72'(bnc), 1);
    bounce_model = bnc;
    wait_for("max_bounces", 72'(bnc), 200);
    check_scene();
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    void'($urandom(32'h1194_f25b));
    value_errors   = 0;
    timeout_errors = 0;
    rst            = 1'b1;
    uart_rxd       = 1'b1;
    obj_rd_addr    = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    test_reset();
    test_camera_loads();
    test_object_table();
    test_count_bounce();
    test_robustness();

    $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src/scene_loader_top.sv ====
`timescale 1ns/1ps

module scene_loader_top import rt_scene_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        uart_rxd,
  output logic        loading,
  output logic [71:0] cam_origin,
  output logic [71:0] cam_right,
  output logic [71:0] cam_forward,
  output logic [71:0] cam_up,
  output logic [7:0]  num_objs_out,
  output logic [7:0]  max_bounces,
  input  logic [3:0]  obj_rd_addr,
  output logic [71:0] obj_rd_data
);

  // ==========================================================================
  // receiver to parser
  // ==========================================================================

  logic       rx_valid;
  logic [7:0] rx_byte;

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst      (rst),
    .rxd      (uart_rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  // ==========================================================================
  // parser to store
  // ==========================================================================

  logic [7:0]                flash_cmd;
  logic [cam_width-1:0]      flash_cam_data;
  logic [obj_width-1:0]      flash_obj_data;
  logic [num_objs_width-1:0] flash_num_objs_data;
  logic [7:0]                flash_max_bounces_data;
  logic                      flash_wen;

  uart_memflash_rtx u_uart_memflash_rtx (
    .clk                    (clk),
    .rst                    (rst),
    .uart_rx_valid          (rx_valid),
    .uart_rx_byte           (rx_byte),
    .flash_active           (loading),
    .flash_cmd              (flash_cmd),
    .flash_cam_data         (flash_cam_data),
    .flash_obj_data         (flash_obj_data),
    .flash_num_objs_data    (flash_num_objs_data),
    .flash_max_bounces_data (flash_max_bounces_data),
    .flash_wen              (flash_wen)
  );

  scene_store u_scene_store (
    .clk                    (clk),
    .rst                    (rst),
    .flash_wen              (flash_wen),
    .flash_cmd              (flash_cmd),
    .flash_cam_data         (flash_cam_data),
    .flash_obj_data         (flash_obj_data),
    .flash_num_objs_data    (flash_num_objs_data),
    .flash_max_bounces_data (flash_max_bounces_data),
    .obj_rd_addr            (obj_rd_addr),
    .cam_origin             (cam_origin),
    .cam_right              (cam_right),
    .cam_forward            (cam_forward),
    .cam_up                 (cam_up),
    .num_objs_out           (num_objs_out),
    .max_bounces            (max_bounces),
    .obj_rd_data            (obj_rd_data)
  );

endmodule

// ==== src/scene_store.sv ====
`timescale 1ns/1ps

module scene_store import rt_scene_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flash_wen,
  input  logic [7:0]                flash_cmd,
  input  logic [71:0]               flash_cam_data,
  input  logic [obj_width-1:0]      flash_obj_data,
  input  logic [num_objs_width-1:0] flash_num_objs_data,
  input  logic [7:0]                flash_max_bounces_data,
  input  logic [obj_idx_width-1:0]  obj_rd_addr,
  output logic [71:0]               cam_origin,
  output logic [71:0]               cam_right,
  output logic [71:0]               cam_forward,
  output logic [71:0]               cam_up,
  output logic [num_objs_width-1:0] num_objs_out,
  output logic [7:0]                max_bounces,
  output logic [obj_width-1:0]      obj_rd_data
);

  logic [obj_width-1:0]     obj_mem [num_objs];
  cam_sel_e                 cam_sel;
  logic                     cam_wen;
  logic                     obj_wen;
  logic                     num_objs_wen;
  logic                     bounce_wen;
  logic [obj_idx_width-1:0] obj_wr_idx;

  // ==========================================================================
  // write target decode
  // ==========================================================================

  assign cam_sel    = cam_sel_e'(flash_cmd[1:0]);
  assign obj_wr_idx = flash_cmd[obj_idx_width-1:0];

  always_comb begin
    cam_wen      = 1'b0;
    obj_wen      = 1'b0;
    num_objs_wen = 1'b0;
    bounce_wen   = 1'b0;
    if (flash_wen) begin
      casez (flash_cmd)
        8'b0???????: obj_wen      = 1'b1;
        8'b1????0??: cam_wen      = 1'b1;
        8'b1????100: num_objs_wen = 1'b1;
        8'b1????101: bounce_wen   = 1'b1;
        default: begin
        end
      endcase
    end
  end

  // ==========================================================================
  // camera, count and bounce registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      cam_origin   <= '0;
      cam_right    <= '0;
      cam_forward  <= '0;
      cam_up       <= '0;
      num_objs_out <= '0;
      max_bounces  <= '0;
    end else begin
      if (cam_wen) begin
        // port names hide the imported enum values.
        case (cam_sel)
          rt_scene_pkg::cam_origin:  cam_origin  <= flash_cam_data;
          rt_scene_pkg::cam_right:   cam_right   <= flash_cam_data;
          rt_scene_pkg::cam_forward: cam_forward <= flash_cam_data;
          rt_scene_pkg::cam_up:      cam_up      <= flash_cam_data;
          default: begin
          end
        endcase
      end
      if (num_objs_wen) begin
        num_objs_out <= flash_num_objs_data;
      end
      if (bounce_wen) begin
        max_bounces <= flash_max_bounces_data;
      end
    end
  end

  // object table, one write port from the parser, one registered read port
  // for the renderer.
  always_ff @(posedge clk) begin
    if (obj_wen) begin
      obj_mem[obj_wr_idx] <= flash_obj_data;
    end
    obj_rd_data <= obj_mem[obj_rd_addr];
  end

endmodule

// ==== src/uart_memflash_rtx.sv ====
`timescale 1ns/1ps

module uart_memflash_rtx import rt_scene_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      uart_rx_valid,
  input  logic [7:0]                uart_rx_byte,
  output logic                      flash_active,
  output logic [7:0]                flash_cmd,
  output logic [71:0]               flash_cam_data,
  output logic [obj_width-1:0]      flash_obj_data,
  output logic [num_objs_width-1:0] flash_num_objs_data,
  output logic [7:0]                flash_max_bounces_data,
  output logic                      flash_wen
);

  // command byte layout:
  //   0 i i i i i i i   object write, low four bits give the entry.
  //   1 x x x x 0 s s   camera write, ss picks the vector.
  //   1 x x x x 1 0 0   object count write.
  //   1 x x x x 1 0 1   bounce depth write.
  //   anything else is ignored.

  parse_state_e                 state;
  logic [$clog2(cam_bytes)-1:0] byte_idx;
  int                           rec_len;
  logic                         rec_done;

  // record length in bytes for the current state.
  always_comb begin
    case (state)
      st_data_cam:      rec_len = cam_bytes;
      st_data_obj:      rec_len = obj_bytes;
      st_data_num_objs: rec_len = num_objs_width / 8;
      default:          rec_len = 1;
    endcase
  end

  assign rec_done = (int'(byte_idx) == rec_len - 1);

  // ==========================================================================
  // parser control
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      byte_idx     <= '0;
      flash_active <= 1'b0;
      flash_wen    <= 1'b0;
    end else begin
      flash_wen <= 1'b0;
      case (state)
        st_idle: begin
          if (uart_rx_valid) begin
            casez (uart_rx_byte)
              8'b0???????: state <= st_data_obj;
              8'b1????0??: state <= st_data_cam;
              8'b1????100: state <= st_data_num_objs;
              8'b1????101: state <= st_data_max_bounces;
              default:     state <= st_idle;
            endcase
            // raised even for an undecoded byte.
            flash_active <= 1'b1;
            byte_idx     <= '0;
          end else begin
            flash_active <= 1'b0;
          end
        end
        st_data_cam,
        st_data_obj,
        st_data_num_objs,
        st_data_max_bounces: begin
          if (uart_rx_valid) begin
            if (rec_done) begin
              byte_idx  <= '0;
              flash_wen <= 1'b1;
              state     <= st_idle;
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ==========================================================================
  // record payload
  // ==========================================================================

  // bytes come in lsb first, so each one enters at the top and the first
  // byte ends up lowest once the record is full.
  always_ff @(posedge clk) begin
    if (uart_rx_valid) begin
      case (state)
        st_idle: begin
          flash_cmd <= uart_rx_byte;
        end
        st_data_cam: begin
          flash_cam_data <= {uart_rx_byte, flash_cam_data[cam_width-1:8]};
        end
        st_data_obj: begin
          flash_obj_data <= {uart_rx_byte, flash_obj_data[obj_width-1:8]};
        end
        st_data_num_objs: begin
          flash_num_objs_data <=
            num_objs_width'({uart_rx_byte, flash_num_objs_data} >> 8);
        end
        st_data_max_bounces: begin
          flash_max_bounces_data <= uart_rx_byte;
        end
        default: begin
        end
      endcase
    end
  end

  // the store sees one write per finished record.
  a_wen_single: assert property (@(posedge clk) disable iff (rst)
    flash_wen |=> !flash_wen);

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import rt_scene_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  logic                            rxd_meta;
  logic                            rxd_sync;
  rx_state_e                       state;
  logic [$clog2(clks_per_bit)-1:0] clk_cnt;
  logic [2:0]                      bit_idx;
  logic [7:0]                      shift_reg;
  logic                            frame_err;

  // two-flop synchronizer, line idles high.
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // ==========================================================================
  // frame state machine
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= rx_idle;
      clk_cnt   <= '0;
      bit_idx   <= '0;
      frame_err <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (!rxd_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // check the start bit at half a bit time.
          if (int'(clk_cnt) == clks_per_bit / 2 - 1) begin
            clk_cnt   <= '0;
            bit_idx   <= '0;
            frame_err <= 1'b0;
            state     <= rxd_sync ? rx_idle : rx_data;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (int'(clk_cnt) == clks_per_bit - 1) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
            bit_idx <= bit_idx + 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_stop: begin
          // a low stop bit marks the frame bad; hold here until the line
          // goes high again so the rest of the bit is not taken as a start.
          if (int'(clk_cnt) == clks_per_bit - 1) begin
            if (rxd_sync) begin
              rx_valid <= !frame_err;
              state    <= rx_idle;
            end else begin
              frame_err <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data bits arrive lsb first.
  always_ff @(posedge clk) begin
    if (state == rx_data && int'(clk_cnt) == clks_per_bit - 1) begin
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
    if (state == rx_stop && int'(clk_cnt) == clks_per_bit - 1 && rxd_sync) begin
      rx_byte <= shift_reg;
    end
  end

  // a frame is at least ten bits long.
  a_valid_single: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid);

endmodule

// ==== src/rt_scene_pkg.sv ====
package rt_scene_pkg;

  // ==========================================================================
  // uart bit timing
  // ==========================================================================

  // clock cycles per serial bit, sampled in the middle.
  localparam int clks_per_bit = 16;

  // ==========================================================================
  // scene record sizes
  // ==========================================================================

  // one camera vector is three 24-bit components.
  localparam int cam_width = 72;
  localparam int cam_bytes = 9;

  // object table depth and index width.
  localparam int num_objs      = 16;
  localparam int obj_idx_width = 4;

  // object record, padded to whole bytes.
  // field order, from bit 0 upward:
  //   [1:0]   shape.
  //   [7:2]   material.
  //   [23:8]  position x.
  //   [39:24] position y.
  //   [55:40] position z.
  //   [71:56] radius.
  localparam int obj_width = 72;
  localparam int obj_bytes = 9;

  // object count register, padded to whole bytes.
  localparam int num_objs_width = 8;

  // ==========================================================================
  // enums
  // ==========================================================================

  // camera vector picked by the two low command bits.
  typedef enum logic [1:0] {
    cam_origin  = 2'd0,
    cam_right   = 2'd1,
    cam_forward = 2'd2,
    cam_up      = 2'd3
  } cam_sel_e;

  // command parser states.
  typedef enum logic [2:0] {
    st_idle,
    st_data_cam,
    st_data_obj,
    st_data_num_objs,
    st_data_max_bounces
  } parse_state_e;

  // serial receiver states.
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

endpackage
